// File: files.f
+incdir+tests
hdl/pbkdf_pkg.sv
hdl/sha256_schedule.sv
hdl/sha256_compress.sv
hdl/pbkdf_sequencer.sv
hdl/pbkdf_hash_store.sv
hdl/pbkdf_engine.sv
tests/pbkdf_engine_properties.sv
tests/pbkdf_engine_tb.sv

// File: hdl/pbkdf_engine.sv
`timescale 1ns/1ns

module pbkdf_engine (
	input logic pbkdf_clk,
	input logic reset,
	input pbkdf_pkg::header_t header,
	input logic load_nonce,
	input logic start,
	output logic done,
	output pbkdf_pkg::result_t result,
	output pbkdf_pkg::word_t nonce_out
);

	pbkdf_pkg::step_t step;
	logic [pbkdf_pkg::BLOCKCNT_W-1:0] block_idx;
	pbkdf_pkg::word_t nonce;	// Nonce for current or next run
	logic hash_done;
	logic sha_start;
	logic sha_done;
	pbkdf_pkg::hash_t digest;
	pbkdf_pkg::sha_req_t req;

	assign done = hash_done;
	assign nonce_out = nonce;

	pbkdf_sequencer i_seq (
		.pbkdf_clk(pbkdf_clk),
		.reset(reset),
		.load_nonce(load_nonce),
		.start(start),
		.nonce_load_value(header.data3[127:96]),	// Nonce slot of header
		.sha_done(sha_done),
		.sha_start(sha_start),
		.step(step),
		.block_idx(block_idx),
		.nonce(nonce),
		.hash_done(hash_done)
	);

	pbkdf_hash_store i_store (
		.pbkdf_clk(pbkdf_clk),
		.reset(reset),
		.header(header),
		.step(step),
		.block_idx(block_idx),
		.nonce(nonce),
		.sha_done(sha_done),
		.digest(digest),
		.hash_done(hash_done),
		.req(req),
		.result(result)
	);

	sha256_compress i_core (
		.pbkdf_clk(pbkdf_clk),
		.reset(reset),
		.sha_start(sha_start),
		.req(req),
		.sha_done(sha_done),
		.digest(digest)
	);

endmodule

// File: hdl/pbkdf_hash_store.sv
`timescale 1ns/1ns

module pbkdf_hash_store (
	input logic pbkdf_clk,
	input logic reset,
	input pbkdf_pkg::header_t header,
	input pbkdf_pkg::step_t step,
	input logic [pbkdf_pkg::BLOCKCNT_W-1:0] block_idx,
	input pbkdf_pkg::word_t nonce,
	input logic sha_done,
	input pbkdf_pkg::hash_t digest,
	input logic hash_done,
	output pbkdf_pkg::sha_req_t req,
	output pbkdf_pkg::result_t result
);

	localparam logic [pbkdf_pkg::BLOCKCNT_W-1:0] LAST_BLK =
		pbkdf_pkg::BLOCKCNT_W'(pbkdf_pkg::NUM_BLOCKS);

	pbkdf_pkg::hash_t khash;	// Key hash of header
	pbkdf_pkg::hash_t ihash;	// IPAD state after header
	pbkdf_pkg::hash_t ohash;	// OPAD state
	pbkdf_pkg::hash_t run_digest;	// Last digest of any step
	logic [1023:0] xbuf;	// T blocks, newest on top
	pbkdf_pkg::word_t blk_word;	// Block index as a word
	logic last_outer;

	assign blk_word = {{(32 - pbkdf_pkg::BLOCKCNT_W){1'b0}}, block_idx};
	assign last_outer = sha_done && (step == pbkdf_pkg::STEP_OUTER) && (block_idx == LAST_BLK);

	always_comb begin
		req.chain = pbkdf_pkg::SHA_IV;	// Fresh hash default
		req.block = {header.data2, header.data1};
		case (step)
			pbkdf_pkg::STEP_KEY_HI: ;	// IV with header head
			pbkdf_pkg::STEP_KEY_LO: begin	// Tail with live nonce
				req.chain = run_digest;
				req.block = {pbkdf_pkg::KEY_TAIL_PAD, nonce, header.data3[95:0]};
			end
			pbkdf_pkg::STEP_IPAD: begin
				req.block = {pbkdf_pkg::IPAD_WORD, khash ^ pbkdf_pkg::IPAD_WORD};
			end
			pbkdf_pkg::STEP_IPAD_PW: begin	// Header head as message
				req.chain = run_digest;
			end
			pbkdf_pkg::STEP_OPAD: begin
				req.block = {pbkdf_pkg::OPAD_WORD, khash ^ pbkdf_pkg::OPAD_WORD};
			end
			pbkdf_pkg::STEP_INNER: begin	// Salt tail plus index
				req.chain = ihash;
				req.block = {pbkdf_pkg::INNER_PAD, blk_word, nonce, header.data3[95:0]};
			end
			pbkdf_pkg::STEP_OUTER: begin
				req.chain = ohash;
				req.block = {pbkdf_pkg::OUTER_PAD, run_digest};
			end
			default: ;
		endcase
	end

	always_ff @(posedge pbkdf_clk) begin
		if (sha_done) begin
			run_digest <= digest;
			case (step)
				pbkdf_pkg::STEP_KEY_LO: khash <= digest;
				pbkdf_pkg::STEP_IPAD_PW: ihash <= digest;
				pbkdf_pkg::STEP_OPAD: ohash <= digest;
				pbkdf_pkg::STEP_OUTER: xbuf <= {digest, xbuf[1023:256]};	// T_i in on top
				default: ;
			endcase
		end else if (hash_done) begin
			xbuf <= '0;	// Clean buffer for next run
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			result <= '0;
		end else if (last_outer) begin	// Same edge that raises done
			result.x <= {digest, xbuf[1023:256]};
			result.nonce <= nonce;
		end
	end

endmodule

// File: hdl/pbkdf_pkg.sv
package pbkdf_pkg;

	// Word i of any block or hash sits at bits [32*i+31:32*i], so W0 and H0 are lowest

	localparam int ROUNDS = 64;	// Rounds per compression
	localparam int ROUND_W = $clog2(ROUNDS);	// Round counter width
	localparam int NUM_BLOCKS = 4;	// Output blocks T1..T4
	localparam int BLOCKCNT_W = 3;	// Holds block index 1..4

	typedef logic [31:0] word_t;	// SHA word
	typedef logic [255:0] hash_t;	// Chaining value or digest
	typedef logic [511:0] block_t;	// Message block

	typedef struct packed {
		logic [255:0] data1;	// Header bytes 0..31
		logic [255:0] data2;	// Header bytes 32..63
		logic [127:0] data3;	// Header bytes 64..79, nonce slot on top
	} header_t;

	typedef struct packed {
		hash_t chain;	// Chaining value in
		block_t block;	// Message block in
	} sha_req_t;

	typedef struct packed {
		logic [1023:0] x;	// T1 lowest, T4 highest
		word_t nonce;	// Nonce used for x
	} result_t;

	typedef enum logic [2:0] {
		STEP_KEY_HI,	// First 64 header bytes
		STEP_KEY_LO,	// Header tail, gives key hash
		STEP_IPAD,	// Key xor IPAD
		STEP_IPAD_PW,	// Header as message, gives IPAD state
		STEP_OPAD,	// Key xor OPAD, gives OPAD state
		STEP_INNER,	// Salt tail and block index
		STEP_OUTER	// Inner digest, gives T_i
	} step_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT
	} seq_state_t;

	localparam hash_t SHA_IV = {
		32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
		32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
	};	// H0 in the low word

	localparam word_t SHA_K [ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam hash_t IPAD_WORD = {32{8'h36}};	// Inner pad bytes
	localparam hash_t OPAD_WORD = {32{8'h5c}};	// Outer pad bytes

	// Padding words, the end marker goes in the lowest word and the bit length on top
	localparam logic [383:0] KEY_TAIL_PAD = {32'h00000280, 320'd0, 32'h80000000};	// 640 bits
	localparam logic [351:0] INNER_PAD = {32'h000004a0, 288'd0, 32'h80000000};	// 1184 bits
	localparam logic [255:0] OUTER_PAD = {32'h00000300, 192'd0, 32'h80000000};	// 768 bits

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));	// Right rotate
	endfunction

endpackage

// File: hdl/pbkdf_sequencer.sv
`timescale 1ns/1ns

module pbkdf_sequencer (
	input logic pbkdf_clk,
	input logic reset,
	input logic load_nonce,
	input logic start,
	input pbkdf_pkg::word_t nonce_load_value,
	input logic sha_done,
	output logic sha_start,
	output pbkdf_pkg::step_t step,
	output logic [pbkdf_pkg::BLOCKCNT_W-1:0] block_idx,
	output pbkdf_pkg::word_t nonce,
	output logic hash_done
);

	localparam logic [pbkdf_pkg::BLOCKCNT_W-1:0] FIRST_BLK = pbkdf_pkg::BLOCKCNT_W'(1);
	localparam logic [pbkdf_pkg::BLOCKCNT_W-1:0] LAST_BLK =
		pbkdf_pkg::BLOCKCNT_W'(pbkdf_pkg::NUM_BLOCKS);

	pbkdf_pkg::seq_state_t state;
	logic last_step;	// Final OUTER of the run

	assign last_step = (step == pbkdf_pkg::STEP_OUTER) && (block_idx == LAST_BLK);
	assign sha_start = (state == pbkdf_pkg::S_ISSUE);	// One cycle per step

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			state <= pbkdf_pkg::S_IDLE;
			step <= pbkdf_pkg::STEP_KEY_HI;
			block_idx <= '0;
			nonce <= '0;
			hash_done <= 1'b0;
		end else begin
			hash_done <= 1'b0;	// Pulse default
			if (load_nonce) begin	// Abort and reload, beats start
				nonce <= nonce_load_value;
				step <= pbkdf_pkg::STEP_KEY_HI;	// Stale core done cannot touch result
				state <= pbkdf_pkg::S_IDLE;
			end else begin
				case (state)
					pbkdf_pkg::S_IDLE: begin
						if (start) begin
							step <= pbkdf_pkg::STEP_KEY_HI;
							block_idx <= FIRST_BLK;
							state <= pbkdf_pkg::S_ISSUE;
						end
					end
					pbkdf_pkg::S_ISSUE: begin
						state <= pbkdf_pkg::S_WAIT;	// Core now busy
					end
					pbkdf_pkg::S_WAIT: begin
						if (sha_done && last_step) begin	// Run complete
							state <= pbkdf_pkg::S_IDLE;
							hash_done <= 1'b1;
							nonce <= nonce + 32'd1;	// Ready for next run
						end else if (sha_done) begin
							state <= pbkdf_pkg::S_ISSUE;
							case (step)
								pbkdf_pkg::STEP_KEY_HI: step <= pbkdf_pkg::STEP_KEY_LO;
								pbkdf_pkg::STEP_KEY_LO: step <= pbkdf_pkg::STEP_IPAD;
								pbkdf_pkg::STEP_IPAD: step <= pbkdf_pkg::STEP_IPAD_PW;
								pbkdf_pkg::STEP_IPAD_PW: step <= pbkdf_pkg::STEP_OPAD;
								pbkdf_pkg::STEP_OPAD: step <= pbkdf_pkg::STEP_INNER;
								pbkdf_pkg::STEP_INNER: step <= pbkdf_pkg::STEP_OUTER;
								pbkdf_pkg::STEP_OUTER: begin	// On to next block
									step <= pbkdf_pkg::STEP_INNER;
									block_idx <= block_idx + FIRST_BLK;
								end
								default: step <= pbkdf_pkg::STEP_KEY_HI;
							endcase
						end
					end
					default: state <= pbkdf_pkg::S_IDLE;
				endcase
			end
		end
	end

endmodule

// File: hdl/sha256_compress.sv
`timescale 1ns/1ns

module sha256_compress (
	input logic pbkdf_clk,
	input logic reset,
	input logic sha_start,
	input pbkdf_pkg::sha_req_t req,
	output logic sha_done,
	output pbkdf_pkg::hash_t digest
);

	localparam logic [pbkdf_pkg::ROUND_W-1:0] LAST_RND = pbkdf_pkg::ROUND_W'(pbkdf_pkg::ROUNDS - 1);

	pbkdf_pkg::hash_t chain;	// Held for feed-forward
	pbkdf_pkg::word_t a, b, c, d, e, f, g, h;	// Working registers
	pbkdf_pkg::word_t w;
	pbkdf_pkg::word_t s0, s1, ch, maj, t1, t2;
	logic busy;
	logic [pbkdf_pkg::ROUND_W-1:0] rnd;

	sha256_schedule i_sched (
		.pbkdf_clk(pbkdf_clk),
		.load(sha_start),
		.block(req.block),
		.advance(busy),
		.w(w)
	);

	assign s1 = pbkdf_pkg::rotr(e, 6) ^ pbkdf_pkg::rotr(e, 11) ^ pbkdf_pkg::rotr(e, 25);
	assign ch = (e & f) ^ (~e & g);
	assign t1 = h + s1 + ch + pbkdf_pkg::SHA_K[rnd] + w;
	assign s0 = pbkdf_pkg::rotr(a, 2) ^ pbkdf_pkg::rotr(a, 13) ^ pbkdf_pkg::rotr(a, 22);
	assign maj = (a & b) ^ (a & c) ^ (b & c);
	assign t2 = s0 + maj;

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			busy <= 1'b0;
			rnd <= '0;
			sha_done <= 1'b0;
		end else begin
			sha_done <= busy && (rnd == LAST_RND);	// Cycle after round 63
			if (sha_start) begin
				busy <= 1'b1;
				rnd <= '0;
			end else if (busy) begin
				rnd <= rnd + 1'b1;
				if (rnd == LAST_RND)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (sha_start) begin	// Load chain into a..h
			chain <= req.chain;
			{h, g, f, e, d, c, b, a} <= req.chain;
		end else if (busy) begin	// One round
			{h, g, f, e} <= {g, f, e, d + t1};
			{d, c, b, a} <= {c, b, a, t1 + t2};
		end
	end

	// Feed-forward add, stable until the next load
	assign digest = {chain[255:224] + h, chain[223:192] + g, chain[191:160] + f,
		chain[159:128] + e, chain[127:96] + d, chain[95:64] + c, chain[63:32] + b,
		chain[31:0] + a};

endmodule

// File: hdl/sha256_schedule.sv
`timescale 1ns/1ns

module sha256_schedule (
	input logic pbkdf_clk,
	input logic load,
	input pbkdf_pkg::block_t block,
	input logic advance,
	output pbkdf_pkg::word_t w
);

	pbkdf_pkg::word_t win [16];	// W[t] up to W[t+15]
	pbkdf_pkg::word_t sig0;
	pbkdf_pkg::word_t sig1;
	pbkdf_pkg::word_t w_next;

	assign sig0 = pbkdf_pkg::rotr(win[1], 7) ^ pbkdf_pkg::rotr(win[1], 18) ^ (win[1] >> 3);
	assign sig1 = pbkdf_pkg::rotr(win[14], 17) ^ pbkdf_pkg::rotr(win[14], 19) ^ (win[14] >> 10);
	assign w_next = sig1 + win[9] + sig0 + win[0];	// W[t+16]
	assign w = win[0];	// Word for this round

	always_ff @(posedge pbkdf_clk) begin
		if (load) begin	// Block words straight in
			for (int k = 0; k < 16; k++) begin
				win[k] <= block[32*k +: 32];
			end
		end else if (advance) begin	// Slide window by one word
			for (int k = 0; k < 15; k++) begin
				win[k] <= win[k+1];
			end
			win[15] <= w_next;
		end
	end

endmodule

// File: tests/pbkdf_engine_properties.sv
`timescale 1ns/1ns

module pbkdf_engine_properties (
	input logic pbkdf_clk,
	input logic reset,
	input logic load_nonce,
	input logic sha_done,
	input logic sha_start,
	input logic hash_done,
	input pbkdf_pkg::seq_state_t state
);

	int fail_count = 0;	// Summed into the closing line

	done_pulse: assert property (@(posedge pbkdf_clk) disable iff (reset)
		hash_done |=> !hash_done)
		else begin
			$error("hash_done lasted more than one cycle");
			fail_count++;
		end

	// Core still working, so no new request next cycle
	no_issue_in_wait: assert property (@(posedge pbkdf_clk) disable iff (reset)
		state == pbkdf_pkg::S_WAIT && !sha_done |=> !sha_start)
		else begin
			$error("sha_start raised while waiting on the core");
			fail_count++;
		end

	load_aborts: assert property (@(posedge pbkdf_clk) disable iff (reset)
		load_nonce |=> state == pbkdf_pkg::S_IDLE)
		else begin
			$error("sequencer not idle after load_nonce");
			fail_count++;
		end

endmodule

bind pbkdf_sequencer pbkdf_engine_properties i_props (
	.pbkdf_clk(pbkdf_clk),
	.reset(reset),
	.load_nonce(load_nonce),
	.sha_done(sha_done),
	.sha_start(sha_start),
	.hash_done(hash_done),
	.state(state)
);

// File: tests/pbkdf_ref.svh
`ifndef PBKDF_REF_SVH
`define PBKDF_REF_SVH

function automatic logic [31:0] rotate_right(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One SHA-256 compression, word i of chain and block at bits [32*i+31:32*i]
function automatic pbkdf_pkg::hash_t compress_block(input pbkdf_pkg::hash_t chain,
		input pbkdf_pkg::block_t blk);
	logic [31:0] w [64];
	logic [31:0] v [8];	// a..h
	logic [31:0] s0, s1, t1, t2;
	pbkdf_pkg::hash_t out;
	for (int t = 0; t < 16; t++)
		w[t] = blk[32*t +: 32];
	for (int t = 16; t < 64; t++) begin	// Message expansion
		s0 = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	for (int i = 0; i < 8; i++)
		v[i] = chain[32*i +: 32];
	for (int t = 0; t < 64; t++) begin
		s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + pbkdf_pkg::SHA_K[t] + w[t];
		s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int i = 7; i > 0; i--)
			v[i] = v[i-1];	// Shift h <- g ... b <- a
		v[4] = v[4] + t1;	// e = d + t1
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		out[32*i +: 32] = chain[32*i +: 32] + v[i];
	return out;
endfunction

// PBKDF2-HMAC-SHA256, header as password and salt, nonce in word 19, four blocks
function automatic logic [1023:0] derive_key(input pbkdf_pkg::header_t hdr,
		input pbkdf_pkg::word_t nonce);
	pbkdf_pkg::block_t blk;
	pbkdf_pkg::hash_t key, istate, ostate, inner;
	logic [1023:0] x;
	key = compress_block(pbkdf_pkg::SHA_IV, {hdr.data2, hdr.data1});
	blk = '0;
	blk[127:0] = {nonce, hdr.data3[95:0]};	// Bytes 64..79
	blk[159:128] = 32'h80000000;
	blk[511:480] = 32'd640;	// 80 bytes
	key = compress_block(key, blk);
	istate = compress_block(pbkdf_pkg::SHA_IV, {{8{32'h36363636}}, key ^ {8{32'h36363636}}});
	istate = compress_block(istate, {hdr.data2, hdr.data1});	// Salt head
	ostate = compress_block(pbkdf_pkg::SHA_IV, {{8{32'h5c5c5c5c}}, key ^ {8{32'h5c5c5c5c}}});
	for (int i = 1; i <= 4; i++) begin
		blk = '0;
		blk[159:0] = {i[31:0], nonce, hdr.data3[95:0]};	// Salt tail, block index
		blk[191:160] = 32'h80000000;
		blk[511:480] = 32'd1184;	// 64 + 80 + 4 bytes
		inner = compress_block(istate, blk);
		blk = '0;
		blk[287:0] = {32'h80000000, inner};
		blk[511:480] = 32'd768;	// 64 + 32 bytes
		x[256*(i-1) +: 256] = compress_block(ostate, blk);
	end
	return x;
endfunction

`endif

// File: tests/pbkdf_engine_tb.sv
`timescale 1ns/1ns

module pbkdf_engine_tb;

	localparam int RUN_LIMIT = 2000;	// 13 compressions need about 860
	localparam int DRAIN_CYCLES = 80;	// Lets an aborted compression finish

	logic pbkdf_clk = 1'b0;
	logic reset;
	pbkdf_pkg::header_t header;
	logic load_nonce;
	logic start;
	logic done;
	pbkdf_pkg::result_t result;
	pbkdf_pkg::word_t nonce_out;

	logic [31:0] lcg_state = 32'hf69d_a87c;
	logic [1023:0] exp_x [$];	// One entry per accepted start
	pbkdf_pkg::word_t exp_nonce [$];
	logic [1023:0] want_x;
	pbkdf_pkg::word_t want_nonce;
	pbkdf_pkg::word_t model_nonce;	// Expected nonce_out
	pbkdf_pkg::word_t rnd_word;
	int done_count = 0;
	int check_errors = 0;
	int other_errors = 0;
	int assert_fails;

	`include "pbkdf_ref.svh"

	pbkdf_engine i_dut (
		.pbkdf_clk(pbkdf_clk),
		.reset(reset),
		.header(header),
		.load_nonce(load_nonce),
		.start(start),
		.done(done),
		.result(result),
		.nonce_out(nonce_out)
	);

	always #2 pbkdf_clk = ~pbkdf_clk;	// 4 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output pbkdf_pkg::word_t value);
		lcg_state = lcg_next(lcg_state);
		value = lcg_state;
	endtask

	task automatic random_header();
		logic [639:0] bits;
		for (int i = 0; i < 20; i++) begin
			lcg_state = lcg_next(lcg_state);
			bits[32*i +: 32] = lcg_state;
		end
		header = bits;
	endtask

	task automatic load_value(input pbkdf_pkg::word_t value);
		header.data3[127:96] = value;	// Nonce slot
		load_nonce = 1'b1;
		@(negedge pbkdf_clk);
		load_nonce = 1'b0;
		model_nonce = value;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge pbkdf_clk);
		start = 1'b0;
	endtask

	task automatic start_run();	// Only from idle
		exp_x.push_back(derive_key(header, model_nonce));
		exp_nonce.push_back(model_nonce);
		pulse_start();
	endtask

	task automatic wait_for_dones(input int target);
		int cycles;
		cycles = 0;
		while (done_count < target && cycles < RUN_LIMIT) begin
			@(posedge pbkdf_clk);	// Count settles at the falling edge
			cycles++;
		end
		if (done_count < target) begin
			$display("Timeout at %0t: done number %0d did not arrive", $time, target);
			other_errors++;
		end else begin
			model_nonce = model_nonce + 32'd1;	// Engine steps the nonce
		end
		@(negedge pbkdf_clk);
	endtask

	task automatic quiet_window(input int cycles, input int expected);
		repeat (cycles) @(posedge pbkdf_clk);
		if (done_count != expected) begin
			$display("CHECK FAILED at %0t: %0d dones seen, expected %0d", $time, done_count,
				expected);
			check_errors++;
		end
		@(negedge pbkdf_clk);
	endtask

	task automatic check_nonce_out(input pbkdf_pkg::word_t expected);
		if (nonce_out !== expected) begin
			$display("CHECK FAILED at %0t: nonce_out %h, expected %h", $time, nonce_out,
				expected);
			check_errors++;
		end
	endtask

	// Compare process, outputs are stable at the falling edge
	always @(negedge pbkdf_clk) begin
		if (!reset && done) begin
			done_count++;
			if (exp_x.size() == 0) begin
				$display("Done at %0t without any accepted start", $time);
				other_errors++;
			end else begin
				want_x = exp_x.pop_front();
				want_nonce = exp_nonce.pop_front();
				if (result.x !== want_x) begin
					$display("CHECK FAILED at %0t: result.x wrong for nonce %h", $time,
						want_nonce);
					check_errors++;
				end
				if (result.nonce !== want_nonce) begin
					$display("CHECK FAILED at %0t: result.nonce %h, expected %h", $time,
						result.nonce, want_nonce);
					check_errors++;
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		header = '0;
		load_nonce = 1'b0;
		start = 1'b0;
		model_nonce = '0;
		repeat (8) @(posedge pbkdf_clk);
		@(negedge pbkdf_clk);
		reset = 1'b0;
		quiet_window(20, 0);	// Idle after reset
		check_nonce_out('0);
		random_header();	// Loaded nonce then one run
		next_random(rnd_word);
		load_value(rnd_word);
		check_nonce_out(rnd_word);
		start_run();
		wait_for_dones(1);
		check_nonce_out(model_nonce);
		next_random(rnd_word);	// Three runs n, n+1, n+2
		load_value(rnd_word);
		for (int k = 0; k < 3; k++) begin
			random_header();
			start_run();
			wait_for_dones(2 + k);
		end
		check_nonce_out(rnd_word + 32'd3);
		random_header();	// Starts while busy
		start_run();
		repeat (100) @(negedge pbkdf_clk);
		pulse_start();
		repeat (300) @(negedge pbkdf_clk);
		pulse_start();
		wait_for_dones(5);
		quiet_window(1000, 5);
		random_header();	// Abort by load_nonce
		pulse_start();
		repeat (300) @(negedge pbkdf_clk);
		next_random(rnd_word);
		load_value(rnd_word);
		quiet_window(DRAIN_CYCLES, 5);
		check_nonce_out(rnd_word);
		start_run();
		wait_for_dones(6);
		check_nonce_out(rnd_word + 32'd1);
		if (exp_x.size() != 0) begin
			$display("%0d expected results never arrived", exp_x.size());
			other_errors++;
		end
		assert_fails = i_dut.i_seq.i_props.fail_count;
		$display("Value errors: %0d, other errors: %0d, assertion failures: %0d, dones: %0d",
			check_errors, other_errors, assert_fails, done_count);
		if (check_errors == 0 && other_errors == 0 && assert_fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
